/* source/fp_format_pkg.sv */
`default_nettype none

package fp_format_pkg;

   // single-precision field widths
   localparam int EXP_W   = 8;
   localparam int FRAC_W  = 23;
   localparam int FP_W    = 1 + EXP_W + FRAC_W;
   localparam int MANT_W  = FRAC_W + 1;

   // guard, round and sticky positions below the mantissa
   localparam int EXT_W   = 3;
   localparam int ALIGN_W = MANT_W + EXT_W;
   // one more bit on top for the carry of an addition
   localparam int SUM_W   = ALIGN_W + 1;

   // shift counts and the padded width of the zero counter
   localparam int SHIFT_W = 5;
   localparam int LZC_W   = 1 << SHIFT_W;

   typedef logic [FP_W-1:0]    fp32_t;
   typedef logic [EXP_W-1:0]   exp_t;
   typedef logic [MANT_W-1:0]  mant_t;
   typedef logic [SUM_W-1:0]   sum_t;
   typedef logic [SHIFT_W-1:0] shift_t;

   function automatic logic fp_sign(fp32_t x);
      return x[FP_W-1];
   endfunction

   function automatic exp_t fp_exp(fp32_t x);
      return x[FP_W-2 -: EXP_W];
   endfunction

   function automatic logic [FRAC_W-1:0] fp_frac(fp32_t x);
      return x[FRAC_W-1:0];
   endfunction

   function automatic fp32_t fp_pack(logic s, exp_t e, logic [FRAC_W-1:0] f);
      return {s, e, f};
   endfunction

endpackage

`default_nettype wire

/* source/fp_pipe_pkg.sv */
`default_nettype none

package fp_pipe_pkg;

   import fp_format_pkg::*;

   // en to y_valid, one register per stage
   localparam int FP_LATENCY = 4;

   // stage 1: operands ordered by magnitude
   typedef struct packed {
      logic  valid;
      logic  eff_sub;
      logic  big_sign;
      exp_t  big_exp;
      mant_t big_mant;
      mant_t small_mant;
      exp_t  exp_diff;
   } prep_s;

   // stage 2: aligned magnitude sum
   // mag holds carry, mantissa, guard, round and sticky
   typedef struct packed {
      logic valid;
      logic sign;
      exp_t exp;
      sum_t mag;
   } sum_s;

   // stage 3: normalized mantissa ready for rounding
   typedef struct packed {
      logic  valid;
      logic  sign;
      exp_t  exp;
      mant_t mant;
      logic  guard;
      logic  sticky;
      logic  zero;
   } norm_s;

endpackage

`default_nettype wire

/* source/count_leading_zeros.sv */
`timescale 1ns/1ps
`default_nettype none

module count_leading_zeros
   import fp_format_pkg::*;
(
   input  sum_t   mag,
   output shift_t zeros,
   output logic   all_zero
);

   // lvl[SHIFT_W] is the padded input, each level halves the window
   logic [LZC_W-1:0] lvl [SHIFT_W:1];

   // carry bit dropped, ones padded below so the count stops at ALIGN_W
   assign lvl[SHIFT_W] = {mag[SUM_W-2:0], {(LZC_W - SUM_W + 1){1'b1}}};

   for (genvar i = SHIFT_W - 1; i >= 0; i--)
   begin : g_halve
      // top 2**i bits all zero sets this count bit
      assign zeros[i] = ~|lvl[i+1][LZC_W-1 -: (1 << i)];

      if (i > 0)
      begin : g_next
         assign lvl[i] = zeros[i] ? (lvl[i+1] << (1 << i)) : lvl[i+1];
      end
   end

   assign all_zero = ~|mag;

endmodule

`default_nettype wire

/* source/fp_operand_prep.sv */
`timescale 1ns/1ps
`default_nettype none

module fp_operand_prep
   import fp_format_pkg::*, fp_pipe_pkg::*;
(
   input  logic  clk,
   input  logic  arst_n,
   input  logic  en,
   input  logic  sub,
   input  fp32_t a,
   input  fp32_t b,
   output prep_s prep
);

   logic  b_sign;
   logic  a_larger;
   exp_t  a_exp;
   exp_t  b_exp;
   mant_t a_mant;
   mant_t b_mant;
   prep_s prep_d;

   always_comb
   begin
      // subtraction is addition with b's sign flipped
      b_sign = fp_sign(b) ^ sub;
      a_exp  = fp_exp(a);
      b_exp  = fp_exp(b);
      a_mant = {1'b1, fp_frac(a)};
      b_mant = {1'b1, fp_frac(b)};

      // exponent first, then mantissa; ties go to a
      a_larger = (a_exp > b_exp) || ((a_exp == b_exp) && (a_mant >= b_mant));

      prep_d.valid   = en;
      prep_d.eff_sub = fp_sign(a) ^ b_sign;
      if (a_larger)
      begin
         prep_d.big_sign   = fp_sign(a);
         prep_d.big_exp    = a_exp;
         prep_d.big_mant   = a_mant;
         prep_d.small_mant = b_mant;
         prep_d.exp_diff   = a_exp - b_exp;
      end
      else
      begin
         prep_d.big_sign   = b_sign;
         prep_d.big_exp    = b_exp;
         prep_d.big_mant   = b_mant;
         prep_d.small_mant = a_mant;
         prep_d.exp_diff   = b_exp - a_exp;
      end
   end

   always_ff @(posedge clk or negedge arst_n)
   begin
      if (!arst_n)
         prep <= '0;
      else if (en)
         prep <= prep_d;
      else
         prep.valid <= 1'b0;
   end

endmodule

`default_nettype wire

/* source/fp_align_add.sv */
`timescale 1ns/1ps
`default_nettype none

module fp_align_add
   import fp_format_pkg::*, fp_pipe_pkg::*;
(
   input  logic  clk,
   input  logic  arst_n,
   input  prep_s prep,
   output sum_s  sum
);

   logic [ALIGN_W-1:0] small_ext;
   logic [ALIGN_W-1:0] small_shift;
   logic [ALIGN_W-1:0] lost_mask;
   logic               sticky;
   sum_t               big_ext;
   sum_s               sum_d;

   // alignment of the smaller operand
   always_comb
   begin
      small_ext = {prep.small_mant, {EXT_W{1'b0}}};
      // bits that fall off the bottom for this distance
      lost_mask = ~({ALIGN_W{1'b1}} << prep.exp_diff);

      if (prep.exp_diff >= exp_t'(ALIGN_W))
      begin
         // nothing left in range, only its sticky survives
         small_shift = '0;
         sticky      = |small_ext;
      end
      else
      begin
         small_shift = small_ext >> prep.exp_diff;
         sticky      = |(small_ext & lost_mask);
      end
      small_shift[0] = small_shift[0] | sticky;
   end

   // magnitude add or subtract
   always_comb
   begin
      big_ext = {1'b0, prep.big_mant, {EXT_W{1'b0}}};

      sum_d.valid = prep.valid;
      sum_d.sign  = prep.big_sign;
      sum_d.exp   = prep.big_exp;
      // big >= small after ordering, so the difference never goes negative
      if (prep.eff_sub)
         sum_d.mag = big_ext - {1'b0, small_shift};
      else
         sum_d.mag = big_ext + {1'b0, small_shift};
   end

   always_ff @(posedge clk or negedge arst_n)
   begin
      if (!arst_n)
         sum <= '0;
      else if (prep.valid)
         sum <= sum_d;
      else
         sum.valid <= 1'b0;
   end

endmodule

`default_nettype wire

/* source/fp_normalize.sv */
`timescale 1ns/1ps
`default_nettype none

module fp_normalize
   import fp_format_pkg::*, fp_pipe_pkg::*;
(
   input  logic  clk,
   input  logic  arst_n,
   input  sum_s  sum,
   output norm_s norm
);

   shift_t lz;
   logic   all_zero;
   sum_t   shifted;
   norm_s  norm_d;

   count_leading_zeros u_clz
   (
      .mag      (sum.mag),
      .zeros    (lz),
      .all_zero (all_zero)
   );

   always_comb
   begin
      norm_d.valid = sum.valid;
      norm_d.sign  = sum.sign;

      if (sum.mag[SUM_W-1])
      begin
         // carry out of the add, one step right
         shifted    = {1'b0, sum.mag[SUM_W-1:1]};
         shifted[0] = shifted[0] | sum.mag[0];
         norm_d.exp = sum.exp + exp_t'(1);
      end
      else
      begin
         // cancellation, pull the leading one up to the hidden bit
         shifted    = sum.mag << lz;
         norm_d.exp = sum.exp - exp_t'(lz);
      end

      // hidden bit sits just below the carry position
      norm_d.mant   = shifted[SUM_W-2 -: MANT_W];
      norm_d.guard  = shifted[EXT_W-1];
      norm_d.sticky = |shifted[EXT_W-2:0];
      norm_d.zero   = all_zero;
   end

   always_ff @(posedge clk or negedge arst_n)
   begin
      if (!arst_n)
         norm <= '0;
      else if (sum.valid)
         norm <= norm_d;
      else
         norm.valid <= 1'b0;
   end

endmodule

`default_nettype wire

/* source/fp_round_pack.sv */
`timescale 1ns/1ps
`default_nettype none

module fp_round_pack
   import fp_format_pkg::*, fp_pipe_pkg::*;
(
   input  logic  clk,
   input  logic  arst_n,
   input  norm_s norm,
   output fp32_t y,
   output logic  y_valid
);

   logic              round_up;
   logic [MANT_W:0]   mant_rnd;
   exp_t              exp_rnd;
   fp32_t             y_d;

   always_comb
   begin
      // nearest even: above half, or exactly half with an odd lsb
      round_up = norm.guard & (norm.sticky | norm.mant[0]);
      mant_rnd = {1'b0, norm.mant} + {{MANT_W{1'b0}}, round_up};

      // carry out of the mantissa bumps the exponent
      exp_rnd = norm.exp + exp_t'(mant_rnd[MANT_W]);

      // on that carry the fraction bits are all zero anyway
      if (norm.zero)
         y_d = '0;
      else
         y_d = fp_pack(norm.sign, exp_rnd, mant_rnd[FRAC_W-1:0]);
   end

   always_ff @(posedge clk or negedge arst_n)
   begin
      if (!arst_n)
      begin
         y       <= '0;
         y_valid <= 1'b0;
      end
      else
      begin
         y_valid <= norm.valid;
         // y holds between results
         if (norm.valid)
            y <= y_d;
      end
   end

endmodule

`default_nettype wire

/* source/fp_add.sv */
`timescale 1ns/1ps
`default_nettype none

module fp_add
   import fp_format_pkg::*, fp_pipe_pkg::*;
(
   input  logic  clk,
   input  logic  arst_n,
   input  logic  en,
   input  logic  sub,
   input  fp32_t a,
   input  fp32_t b,
   output fp32_t y,
   output logic  y_valid
);

   prep_s prep;
   sum_s  sum;
   norm_s norm;

   // stage 1, sign fixup and ordering
   fp_operand_prep u_prep
   (
      .clk    (clk),
      .arst_n (arst_n),
      .en     (en),
      .sub    (sub),
      .a      (a),
      .b      (b),
      .prep   (prep)
   );

   // stage 2, align and add
   fp_align_add u_align
   (
      .clk    (clk),
      .arst_n (arst_n),
      .prep   (prep),
      .sum    (sum)
   );

   // stage 3
   fp_normalize u_norm
   (
      .clk    (clk),
      .arst_n (arst_n),
      .sum    (sum),
      .norm   (norm)
   );

   // stage 4, round and output register
   fp_round_pack u_round
   (
      .clk     (clk),
      .arst_n  (arst_n),
      .norm    (norm),
      .y       (y),
      .y_valid (y_valid)
   );

endmodule

`default_nettype wire

/* tests/fp_add_props.sv */
`timescale 1ns/1ps
`default_nettype none

module fp_add_props
   import fp_format_pkg::*, fp_pipe_pkg::*;
(
   input logic  clk,
   input logic  arst_n,
   input logic  en,
   input fp32_t y,
   input logic  y_valid
);

   int fail_count = 0;

   // every strobe comes out exactly FP_LATENCY edges later
   a_latency: assert property (@(posedge clk) disable iff (!arst_n)
      y_valid == $past(en, FP_LATENCY))
   else
   begin
      $error("y_valid does not follow en by the pipeline latency");
      fail_count++;
   end

   a_reset_quiet: assert property (@(posedge clk) !arst_n |-> !y_valid)
   else
   begin
      $error("y_valid high during reset");
      fail_count++;
   end

   // a valid result is fully defined
   a_y_known: assert property (@(posedge clk) disable iff (!arst_n)
      y_valid |-> !$isunknown(y))
   else
   begin
      $error("y has unknown bits while y_valid is high");
      fail_count++;
   end

endmodule

`default_nettype wire

/* tests/fp_add_tb.sv */
`timescale 1ns/1ps
`default_nettype none

module fp_add_tb
   import fp_format_pkg::*, fp_pipe_pkg::*;
();

   localparam int    PERIOD     = 100;
   localparam int    WAIT_LIMIT = 40;
   localparam fp32_t ONE        = 32'h3f80_0000;

   logic  clk;
   logic  arst_n;
   logic  en;
   logic  sub;
   fp32_t a;
   fp32_t b;
   fp32_t y;
   logic  y_valid;

   // expected results and the negedge each one is due at
   fp32_t exp_q [$];
   int    due_q [$];
   int    negedges = 0;
   int    errors   = 0;
   int    checks   = 0;
   int    tests    = 0;
   int    mark     = 0;
   int    ea;
   int    eb;

   fp_add uut (.clk, .arst_n, .en, .sub, .a, .b, .y, .y_valid);

   bind fp_add fp_add_props u_props (.clk, .arst_n, .en, .y, .y_valid);

   initial
   begin
      clk = 1'b0;
      forever #(PERIOD / 2) clk = ~clk;
   end

   function automatic fp32_t make_fp(logic s, int e, logic [22:0] f);
      return {s, 8'(e), f};
   endfunction

   // single word widened to a double, exact
   function automatic real to_real(fp32_t x);
      logic [10:0] e;
      e = {3'b000, x[30:23]} + 11'd896;
      return $bitstoreal({x[31], e, x[22:0], 29'd0});
   endfunction

   // double narrowed to single with nearest even
   function automatic fp32_t round_single(real r);
      logic [63:0] d;
      logic [24:0] m;
      logic [7:0]  e;
      d = $realtobits(r);
      if (d[62:0] == '0)
         return '0;
      e = 8'(d[62:52] - 11'd896);
      m = {2'b01, d[51:29]};
      if (d[28] && ((|d[27:0]) || m[0]))
         m = m + 25'd1;
      if (m[24])
      begin
         e = e + 8'd1;
         m = m >> 1;
      end
      return {d[63], e, m[22:0]};
   endfunction

   task automatic issue(fp32_t x, fp32_t z, logic s);
      @(posedge clk);
      a   <= x;
      b   <= z;
      sub <= s;
      en  <= 1'b1;
      exp_q.push_back(round_single(s ? to_real(x) - to_real(z) : to_real(x) + to_real(z)));
      // the negedge before the sampling edge, then one per pipeline stage
      due_q.push_back(negedges + FP_LATENCY + 1);
   endtask

   task automatic end_test(string name);
      int n;
      n = 0;
      while (exp_q.size() != 0 && n < WAIT_LIMIT)
      begin
         @(posedge clk);
         en <= 1'b0;
         n++;
      end
      if (exp_q.size() != 0)
      begin
         $display("timeout in %s: %0d results never arrived", name, exp_q.size());
         errors++;
         exp_q.delete();
         due_q.delete();
      end
      tests++;
      $display("test %-12s %s", name, (errors == mark) ? "ok" : "had errors");
      mark = errors;
   endtask

   task automatic check_result(fp32_t want, int due);
      checks++;
      assert (y === want)
      else
      begin
         $display("FAILED at %0t: y expected %h, got %h", $time, want, y);
         errors++;
      end
      assert (negedges == due)
      else
      begin
         $display("result at %0t arrived %0d cycles off its latency", $time, negedges - due);
         errors++;
      end
   endtask

   // outputs are stable at the falling edge
   always @(negedge clk)
   begin
      negedges = negedges + 1;
      if (y_valid && exp_q.size() == 0)
      begin
         $display("y_valid high at %0t with no operation outstanding", $time);
         errors++;
      end
      else if (y_valid)
         check_result(exp_q.pop_front(), due_q.pop_front());
   end

   initial
   begin
      void'($urandom(84210));
      arst_n = 1'b0;
      en     = 1'b0;
      sub    = 1'b0;
      a      = '0;
      b      = '0;
      repeat (4) @(posedge clk);
      arst_n <= 1'b1;

      // quiet until the first operation, then a single pulse
      repeat (3) @(posedge clk);
      issue(ONE, 32'h4000_0000, 1'b0);
      end_test("reset");

      issue(ONE, 32'h4000_0000, 1'b0);
      issue(32'h3fc0_0000, 32'h3e80_0000, 1'b0);
      issue(32'h3fc0_0000, 32'h3fc0_0000, 1'b0);
      issue(32'h4040_0000, ONE, 1'b0);
      issue(32'hc000_0000, 32'h3f00_0000, 1'b0);
      end_test("add");

      issue(32'h40a0_0000, 32'h4040_0000, 1'b1);
      issue(32'h4040_0000, 32'h40a0_0000, 1'b1);
      issue(32'h3fc0_0000, 32'h3fc0_0000, 1'b1);
      issue(32'hbfa0_0000, 32'hbfa0_0000, 1'b1);
      issue(32'h4120_0000, 32'hc120_0000, 1'b0);
      end_test("subtract");

      // neighbours one fraction bit apart, up to a shift of 23
      for (int k = 0; k < 23; k++)
         issue(make_fp(1'b0, 130, 23'h2a_5a5a),
               make_fp(1'b0, 130, 23'h2a_5a5a ^ (23'd1 << k)), 1'b1);
      issue(make_fp(1'b0, 127, 23'h7f_ffff), make_fp(1'b0, 126, 23'h7f_ffff), 1'b1);
      end_test("cancel");

      // ties to even, just above a tie, carries from rounding
      issue(ONE, make_fp(1'b0, 103, 23'h0), 1'b0);
      issue(make_fp(1'b0, 127, 23'h1), make_fp(1'b0, 103, 23'h0), 1'b0);
      issue(ONE, make_fp(1'b0, 103, 23'h02_0000), 1'b0);
      issue(make_fp(1'b0, 127, 23'h7f_ffff), make_fp(1'b0, 103, 23'h0), 1'b0);
      issue(ONE, make_fp(1'b0, 97, 23'h0), 1'b1);
      issue(ONE, make_fp(1'b0, 90, 23'h12_3456), 1'b0);
      end_test("round");

      for (int i = 0; i < 200; i++)
      begin
         ea = 60 + int'($urandom % 131);
         eb = ea + int'($urandom % 41) - 20;
         eb = (eb < 60) ? 60 : ((eb > 190) ? 190 : eb);
         issue(make_fp(1'($urandom), ea, 23'($urandom)),
               make_fp(1'($urandom), eb, 23'($urandom)), 1'($urandom));
      end
      end_test("stream");

      errors = errors + uut.u_props.fail_count;
      $display("%0d tests, %0d results checked, %0d errors", tests, checks, errors);
      if (errors == 0)
         $display("ALL TESTS PASSED");
      else
         $display("SOME TESTS FAILED");
      $finish;
   end

endmodule

`default_nettype wire

/* fp_add.f */
source/fp_format_pkg.sv
source/fp_pipe_pkg.sv
source/count_leading_zeros.sv
source/fp_operand_prep.sv
source/fp_align_add.sv
source/fp_normalize.sv
source/fp_round_pack.sv
source/fp_add.sv
tests/fp_add_props.sv
tests/fp_add_tb.sv

/* run_sim.sh */
#!/usr/bin/env bash
# build and run the fp_add testbench with Verilator
set -e
cd "$(dirname "$0")"

rm -rf obj_dir
verilator --binary --timing --assert -Wno-fatal --top-module fp_add_tb -f fp_add.f
./obj_dir/Vfp_add_tb +verilator+error+limit+100 2>&1 | tee sim.log

if grep -q "ALL TESTS PASSED" sim.log; then
   echo "simulation passed"
else
   echo "simulation failed, see sim.log"
   exit 1
fi
